// File: source/core_defs_pkg.sv
/* Thread, word and control register definitions shared by the I/O access path.
   The thread count is fixed at 4; widths derived from it assume a power of two. */

package core_defs_pkg;

    localparam int threads_per_core = 4;                   // Hardware threads per core
    localparam int thread_idx_width = $clog2(threads_per_core);
    localparam int scalar_width = 32;                      // Data word width
    localparam int creg_index_width = 4;                   // Control register index width

    typedef logic [thread_idx_width - 1:0] thread_idx_t;   // Thread number
    typedef logic [threads_per_core - 1:0] thread_bitmap_t; // One bit per thread
    typedef logic [scalar_width - 1:0] scalar_t;           // Data word

    // Control register index, as seen in the low address bits of a creg access
    typedef enum logic [creg_index_width - 1:0] {
        cr_thread_id    = 4'd0,     // Read only, accessing thread
        cr_trap_handler = 4'd1,     // Global, read/write
        cr_cycle_count  = 4'd6,     // Read only, free running
        cr_scratchpad0  = 4'd11,    // Per thread, read/write
        cr_scratchpad1  = 4'd12     // Per thread, read/write
    } control_register_t;

endpackage

// File: source/io_bus_pkg.sv
/* Address decoding for accesses leaving the core. Upper 16 bits select the region;
   the control register region is ffff, every other region goes to the I/O bus. */

package io_bus_pkg;

    localparam int region_width = 16;                          // Upper address half
    localparam int offset_width = 16;                          // Device offset
    localparam logic [region_width - 1:0] creg_region = 16'hffff; // Control register window

    // Plain I/O view of an access address
    typedef struct packed {
        logic [region_width - 1:0] region;     // Target region
        logic [offset_width - 1:0] offset;     // Device offset
    } io_addr_t;

    // Control register view of the same word
    typedef struct packed {
        logic [region_width - 1:0] region;     // Equals creg_region
        logic [9:0] reserved;                  // Ignored
        core_defs_pkg::control_register_t index; // Register select
        logic [1:0] byte_offset;               // Word aligned, ignored
    } creg_addr_t;

    // One 32 bit access address, decoded either way
    typedef union packed {
        io_addr_t io;                          // Region and device offset
        creg_addr_t creg;                      // Region and register index
    } access_addr_u;

endpackage

// File: source/io_access_if.sv
`timescale 1ns/100ps
/* Enqueue and completion signals between the dispatcher and the I/O request queue.
   Enqueue is only valid for threads whose pending bit is clear. */

interface io_access_if;
    import core_defs_pkg::*;

    logic enq_en;                  // One cycle enqueue strobe
    thread_idx_t enq_thread;       // Owning thread
    logic enq_store;               // Store when high, load when low
    scalar_t enq_addr;             // Full access address
    scalar_t enq_value;            // Store data

    thread_bitmap_t pending;       // Threads with an outstanding request
    logic done_valid;              // Completion pulse
    thread_idx_t done_thread;      // Completing thread
    scalar_t done_value;           // Load data, zero for stores

    modport dispatch (
        output enq_en, enq_thread, enq_store, enq_addr, enq_value,
        input pending
    );

    modport queue (
        input enq_en, enq_thread, enq_store, enq_addr, enq_value,
        output pending, done_valid, done_thread, done_value
    );

endinterface

// File: source/access_dispatch.sv
`timescale 1ns/100ps
/* Routes each access by region. Control register accesses pass through combinationally;
   an I/O access from a thread that is already pending is dropped and rolled back. */

module access_dispatch (
    input clk,
    input reset,
    input access_en,
    input core_defs_pkg::thread_idx_t access_thread,
    input access_store,
    input io_bus_pkg::access_addr_u access_addr,
    input core_defs_pkg::scalar_t access_value,
    output logic access_rollback,
    output core_defs_pkg::thread_idx_t rollback_thread,
    output logic creg_en,
    output logic creg_store,
    output core_defs_pkg::control_register_t creg_index,
    output core_defs_pkg::thread_idx_t creg_thread,
    output core_defs_pkg::scalar_t creg_value,
    io_access_if.dispatch io
);
    import core_defs_pkg::*;
    import io_bus_pkg::*;

    logic is_creg;         // Address falls in the control register window
    logic io_access;       // Access bound for the I/O bus
    logic thread_busy;     // Thread already has a request outstanding

    assign is_creg = access_addr.io.region == creg_region;     // Region from the I/O view
    assign io_access = access_en && !is_creg;
    assign thread_busy = io.pending[access_thread];

    // Control register side, same cycle
    assign creg_en = access_en && is_creg;
    assign creg_store = access_store;
    assign creg_index = access_addr.creg.index;                 // Index from the creg view
    assign creg_thread = access_thread;
    assign creg_value = access_value;

    // I/O side, only free threads enqueue
    assign io.enq_en = io_access && !thread_busy;
    assign io.enq_thread = access_thread;
    assign io.enq_store = access_store;
    assign io.enq_addr = access_addr;                           // Whole word to the bus
    assign io.enq_value = access_value;

    // Rollback one cycle after a rejected access
    always_ff @(posedge clk) begin
        if (reset) begin
            access_rollback <= 1'b0;
        end else begin
            access_rollback <= io_access && thread_busy;
        end
    end

    always_ff @(posedge clk) begin
        if (io_access && thread_busy) begin
            rollback_thread <= access_thread;                   // Held until next rollback
        end
    end

endmodule

// File: source/control_registers.sv
`timescale 1ns/100ps
/* Control register file with per-thread scratchpads, a shared trap handler and a cycle
   counter. Results appear one cycle after the strobe and return the value before a write. */

module control_registers (
    input clk,
    input reset,
    input creg_en,
    input creg_store,
    input core_defs_pkg::control_register_t creg_index,
    input core_defs_pkg::thread_idx_t creg_thread,
    input core_defs_pkg::scalar_t creg_value,
    output logic creg_result_valid,
    output core_defs_pkg::thread_idx_t creg_result_thread,
    output core_defs_pkg::scalar_t creg_result_value
);
    import core_defs_pkg::*;

    scalar_t scratchpad0[threads_per_core];    // Per thread
    scalar_t scratchpad1[threads_per_core];    // Per thread
    scalar_t trap_handler;                     // Shared by all threads
    scalar_t cycle_count;                      // Cycles since reset
    scalar_t read_value;                       // Selected register, before write

    // Free running counter
    always_ff @(posedge clk) begin
        if (reset) begin
            cycle_count <= '0;
        end else begin
            cycle_count <= cycle_count + 1'b1;
        end
    end

    // Read select
    always_comb begin
        case (creg_index)
            cr_thread_id: read_value = scalar_t'(creg_thread);     // Zero extended
            cr_trap_handler: read_value = trap_handler;
            cr_cycle_count: read_value = cycle_count;
            cr_scratchpad0: read_value = scratchpad0[creg_thread];
            cr_scratchpad1: read_value = scratchpad1[creg_thread];
            default: read_value = '0;                             // Unknown index
        endcase
    end

    // Register writes land at the result edge
    always_ff @(posedge clk) begin
        if (reset) begin
            trap_handler <= '0;
            for (int i = 0; i < threads_per_core; i++) begin
                scratchpad0[i] <= '0;
                scratchpad1[i] <= '0;
            end
        end else if (creg_en && creg_store) begin
            case (creg_index)
                cr_trap_handler: trap_handler <= creg_value;
                cr_scratchpad0: scratchpad0[creg_thread] <= creg_value;
                cr_scratchpad1: scratchpad1[creg_thread] <= creg_value;
                default: ;                                        // Read only or unknown
            endcase
        end
    end

    // Result strobe
    always_ff @(posedge clk) begin
        if (reset) begin
            creg_result_valid <= 1'b0;
        end else begin
            creg_result_valid <= creg_en;
        end
    end

    always_ff @(posedge clk) begin
        if (creg_en) begin
            creg_result_thread <= creg_thread;
            creg_result_value <= read_value;                      // Old value on writes
        end
    end

endmodule

// File: source/io_request_queue.sv
`timescale 1ns/100ps
/* One request slot per thread, issued round robin onto the I/O bus. Responses may
   return in any order but only for threads whose request has already transferred. */

module io_request_queue (
    input clk,
    input reset,
    input ii_ready,
    input ii_response_valid,
    input core_defs_pkg::thread_idx_t ii_response_thread,
    input core_defs_pkg::scalar_t ii_response_value,
    output logic ior_request_valid,
    output core_defs_pkg::thread_idx_t ior_request_thread,
    output logic ior_request_store,
    output core_defs_pkg::scalar_t ior_request_address,
    output core_defs_pkg::scalar_t ior_request_value,
    io_access_if.queue io
);
    import core_defs_pkg::*;

    thread_bitmap_t slot_pending;              // Slot holds a request
    thread_bitmap_t slot_sent;                 // Request has transferred
    logic slot_store[threads_per_core];        // Request payload
    scalar_t slot_addr[threads_per_core];
    scalar_t slot_value[threads_per_core];

    thread_bitmap_t unsent;                    // Waiting for the bus
    thread_bitmap_t enq_oh;                    // Slot filled this cycle
    thread_bitmap_t send_oh;                   // Slot transferring this cycle
    thread_bitmap_t resp_oh;                   // Slot answered this cycle
    thread_idx_t last_grant;                   // Round robin pointer
    thread_idx_t grant_thread;                 // Next slot after the pointer
    logic grant_found;                         // Some slot is waiting
    logic held_valid;                          // Request stalled by ii_ready
    thread_idx_t held_thread;                  // Stalled slot
    logic transfer;                            // Bus handshake this cycle

    logic done_valid;                          // Completion registers
    thread_idx_t done_thread;
    scalar_t done_value;

    assign unsent = slot_pending & ~slot_sent;

    // Round robin search, starting one past the last grant
    always_comb begin
        thread_idx_t candidate;

        grant_found = 1'b0;
        grant_thread = last_grant;
        for (int i = 1; i <= threads_per_core; i++) begin
            candidate = thread_idx_t'(last_grant + i);        // Wraps at thread count
            if (!grant_found && unsent[candidate]) begin
                grant_found = 1'b1;
                grant_thread = candidate;
            end
        end
    end

    // Bus side, stalled requests stay put
    assign ior_request_valid = held_valid || grant_found;
    assign ior_request_thread = held_valid ? held_thread : grant_thread;
    assign ior_request_store = slot_store[ior_request_thread];
    assign ior_request_address = slot_addr[ior_request_thread];
    assign ior_request_value = slot_value[ior_request_thread];
    assign transfer = ior_request_valid && ii_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            held_valid <= 1'b0;
            last_grant <= thread_idx_t'(threads_per_core - 1);  // Thread 0 goes first
        end else if (transfer) begin
            held_valid <= 1'b0;
            last_grant <= ior_request_thread;
        end else if (ior_request_valid) begin
            held_valid <= 1'b1;                                  // Lock the pick
        end
    end

    always_ff @(posedge clk) begin
        held_thread <= ior_request_thread;                       // Stable once held
    end

    // Slot bookkeeping
    assign enq_oh = io.enq_en ? thread_bitmap_t'(1) << io.enq_thread : '0;
    assign send_oh = transfer ? thread_bitmap_t'(1) << ior_request_thread : '0;
    assign resp_oh = ii_response_valid ? thread_bitmap_t'(1) << ii_response_thread : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            slot_pending <= '0;
            slot_sent <= '0;
        end else begin
            slot_pending <= (slot_pending | enq_oh) & ~resp_oh;
            slot_sent <= (slot_sent | send_oh) & ~resp_oh;
        end
    end

    always_ff @(posedge clk) begin
        if (io.enq_en) begin
            slot_store[io.enq_thread] <= io.enq_store;
            slot_addr[io.enq_thread] <= io.enq_addr;
            slot_value[io.enq_thread] <= io.enq_value;
        end
    end

    // Completion one cycle after the response
    always_ff @(posedge clk) begin
        if (reset) begin
            done_valid <= 1'b0;
        end else begin
            done_valid <= ii_response_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ii_response_valid) begin
            done_thread <= ii_response_thread;
            done_value <= slot_store[ii_response_thread] ? '0 : ii_response_value;
        end
    end

    assign io.pending = slot_pending;
    assign io.done_valid = done_valid;
    assign io.done_thread = done_thread;
    assign io.done_value = done_value;

endmodule

// File: source/io_access_unit.sv
`timescale 1ns/100ps
/* Uncached access path for 4 threads. Accesses are single cycle strobes; at most
   one I/O request per thread may be outstanding, a second one is rolled back. */

module io_access_unit (
    input clk,
    input reset,

    // Thread accesses
    input access_en,
    input core_defs_pkg::thread_idx_t access_thread,
    input access_store,
    input io_bus_pkg::access_addr_u access_addr,
    input core_defs_pkg::scalar_t access_value,
    output logic access_rollback,
    output core_defs_pkg::thread_idx_t rollback_thread,

    // Control register read result
    output logic creg_result_valid,
    output core_defs_pkg::thread_idx_t creg_result_thread,
    output core_defs_pkg::scalar_t creg_result_value,

    // I/O bus
    output logic ior_request_valid,
    output core_defs_pkg::thread_idx_t ior_request_thread,
    output logic ior_request_store,
    output core_defs_pkg::scalar_t ior_request_address,
    output core_defs_pkg::scalar_t ior_request_value,
    input ii_ready,
    input ii_response_valid,
    input core_defs_pkg::thread_idx_t ii_response_thread,
    input core_defs_pkg::scalar_t ii_response_value,

    // I/O completion
    output logic io_done_valid,
    output core_defs_pkg::thread_idx_t io_done_thread,
    output core_defs_pkg::scalar_t io_read_value
);
    import core_defs_pkg::*;

    logic creg_en;                     // Control register strobe
    logic creg_store;                  // Write access
    control_register_t creg_index;     // Selected register
    thread_idx_t creg_thread;          // Accessing thread
    scalar_t creg_value;               // Write data

    io_access_if io_bus ();

    access_dispatch u_access_dispatch (.*, .io(io_bus.dispatch));

    control_registers u_control_registers (.*);

    io_request_queue u_io_request_queue (.*, .io(io_bus.queue));

    assign io_done_valid = io_bus.done_valid;      // Completion out of the queue
    assign io_done_thread = io_bus.done_thread;
    assign io_read_value = io_bus.done_value;

endmodule

// File: testbench/io_access_unit_sva.sv
`timescale 1ns/100ps
/* I/O bus protocol checks bound into io_request_queue. All checks are off during reset. */

module io_access_unit_sva (
    input clk,
    input reset,
    input ii_ready,
    input ii_response_valid,
    input core_defs_pkg::thread_idx_t ii_response_thread,
    input ior_request_valid,
    input core_defs_pkg::thread_idx_t ior_request_thread,
    input ior_request_store,
    input core_defs_pkg::scalar_t ior_request_address,
    input core_defs_pkg::scalar_t ior_request_value,
    input core_defs_pkg::thread_bitmap_t slot_pending,
    input core_defs_pkg::thread_bitmap_t slot_sent,
    input done_valid,
    input core_defs_pkg::thread_idx_t done_thread
);

    // Stalled request keeps every field
    assert property (@(posedge clk) disable iff (reset)
        ior_request_valid && !ii_ready |=> ior_request_valid && $stable(ior_request_thread)
            && $stable(ior_request_store) && $stable(ior_request_address)
            && $stable(ior_request_value))
        else $error("I/O request changed while stalled");

    // Responses only for requests already transferred
    assert property (@(posedge clk) disable iff (reset)
        ii_response_valid |-> slot_sent[ii_response_thread])
        else $error("Response for a thread with no request sent");

    // Completion frees the answering thread's slot
    assert property (@(posedge clk) disable iff (reset)
        ii_response_valid |=> done_valid && done_thread == $past(ii_response_thread)
            && !slot_pending[done_thread] && !slot_sent[done_thread])
        else $error("Completion missing or slot still busy after a response");

endmodule

bind io_request_queue io_access_unit_sva u_io_access_unit_sva (
    .clk(clk), .reset(reset), .ii_ready(ii_ready),
    .ii_response_valid(ii_response_valid), .ii_response_thread(ii_response_thread),
    .ior_request_valid(ior_request_valid), .ior_request_thread(ior_request_thread),
    .ior_request_store(ior_request_store), .ior_request_address(ior_request_address),
    .ior_request_value(ior_request_value), .slot_pending(slot_pending),
    .slot_sent(slot_sent), .done_valid(done_valid), .done_thread(done_thread)
);

// File: testbench/io_access_unit_tb.sv
`timescale 1ns/100ps
/* Random testbench for io_access_unit with a reference model and an I/O bus responder.
   The responder answers accepted requests in random order. The seed is fixed at 4. */

module io_access_unit_tb;
    import core_defs_pkg::*;
    import io_bus_pkg::*;

    localparam int clk_period = 100;                   // ns
    localparam int reset_cycles = 10;
    localparam int drain_limit = 200;                  // Cycles allowed to empty the queue
    localparam int test_cycles = 200 + 150 + 300 + 120 + 400 + 180;
    localparam int watchdog_cycles = reset_cycles + test_cycles + 6 * (drain_limit + 1) + 200;

    logic clk = 1'b0;
    logic reset;
    logic access_en;
    thread_idx_t access_thread;
    logic access_store;
    access_addr_u access_addr;
    scalar_t access_value;
    logic access_rollback;
    thread_idx_t rollback_thread;
    logic creg_result_valid;
    thread_idx_t creg_result_thread;
    scalar_t creg_result_value;
    logic ior_request_valid;
    thread_idx_t ior_request_thread;
    logic ior_request_store;
    scalar_t ior_request_address;
    scalar_t ior_request_value;
    logic ii_ready;
    logic ii_response_valid;
    thread_idx_t ii_response_thread;
    scalar_t ii_response_value;
    logic io_done_valid;
    thread_idx_t io_done_thread;
    scalar_t io_read_value;

    int seed = 4;
    scalar_t sp0[threads_per_core];                    // Model registers
    scalar_t sp1[threads_per_core];
    scalar_t trap;
    scalar_t cycles;                                   // Cycles since reset ended
    logic busy[threads_per_core];                      // Model pending bits
    logic sent[threads_per_core];                      // Already on the bus
    logic req_store[threads_per_core];                 // Expected request fields
    scalar_t req_addr[threads_per_core];
    scalar_t req_value[threads_per_core];
    thread_idx_t accepted[$];                          // Waiting for a response
    logic exp_creg;                                    // Pulses due this cycle
    logic exp_rollback;
    logic exp_done;
    thread_idx_t exp_creg_thread;
    thread_idx_t exp_rollback_thread;
    thread_idx_t exp_done_thread;
    scalar_t exp_creg_value;
    scalar_t exp_done_value;
    int errors = 0;
    int test_errors;
    int tests_run = 0;
    int tests_failed = 0;
    int rollbacks_seen;

    io_access_unit u_io_access_unit (.*);

    always #(clk_period / 2) clk = ~clk;

    initial begin
        #(watchdog_cycles * clk_period);
        $display("Timeout: the run did not finish within %0d cycles", watchdog_cycles);
        $display("STATUS: FAIL");
        $finish;
    end

    function automatic int rand_below(int n);
        int r;
        r = $random(seed) & 32'h7fff_ffff;             // Non-negative
        return r % n;
    endfunction

    function automatic control_register_t pick_index(int mode);
        if (mode == 1) begin
            return rand_below(2) == 0 ? cr_thread_id : cr_cycle_count;
        end
        case (rand_below(4))
            0: return cr_scratchpad0;
            1: return cr_scratchpad1;
            2: return cr_trap_handler;
            default: return control_register_t'(4'(rand_below(16)));  // Mostly unused
        endcase
    endfunction

    function automatic logic any_pending(logic unsent_only);
        for (int i = 0; i < threads_per_core; i++) begin
            if (busy[i] && !(unsent_only && sent[i])) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic report_failure(string msg);
        $display("%s", msg);
        errors++;
        test_errors++;
    endtask

    task automatic report_error(string msg);
        report_failure($sformatf("Error at %0d ns: %s", $time, msg));
    endtask

    task automatic check_pulse(string name, logic got, logic expected);
        if (got !== expected) begin
            report_error($sformatf("%s is %b, expected %b", name, got, expected));
        end
    endtask

    task automatic check_creg_result(thread_idx_t thread, scalar_t value);
        if (creg_result_thread !== thread || creg_result_value !== value) begin
            report_error($sformatf("creg result thread %0d value %h, expected %0d %h",
                creg_result_thread, creg_result_value, thread, value));
        end
    endtask

    task automatic check_rollback(thread_idx_t thread);
        if (rollback_thread !== thread) begin
            report_error($sformatf("rollback thread %0d, expected %0d", rollback_thread, thread));
        end
    endtask

    task automatic check_io_request(thread_idx_t thread, logic store, scalar_t addr,
                                    scalar_t value);
        if (ior_request_thread !== thread || ior_request_store !== store ||
            ior_request_address !== addr || ior_request_value !== value) begin
            report_error($sformatf("request %0d %b %h %h, expected %0d %b %h %h",
                ior_request_thread, ior_request_store, ior_request_address,
                ior_request_value, thread, store, addr, value));
        end
    endtask

    task automatic check_io_done(thread_idx_t thread, scalar_t value);
        if (io_done_thread !== thread || io_read_value !== value) begin
            report_error($sformatf("completion thread %0d value %h, expected %0d %h",
                io_done_thread, io_read_value, thread, value));
        end
    endtask

    task automatic idle_inputs();
        access_en = 1'b0;
        access_thread = '0;
        access_store = 1'b0;
        access_addr = '0;
        access_value = '0;
        ii_ready = 1'b0;
        ii_response_valid = 1'b0;
        ii_response_thread = '0;
        ii_response_value = '0;
    endtask

    task automatic clear_model();
        for (int i = 0; i < threads_per_core; i++) begin
            sp0[i] = '0;
            sp1[i] = '0;
            busy[i] = 1'b0;
            sent[i] = 1'b0;
        end
        trap = '0;
        cycles = '0;
        accepted.delete();                             // Responder forgets old requests
        exp_creg = 1'b0;
        exp_rollback = 1'b0;
        exp_done = 1'b0;
    endtask

    task automatic apply_reset();
        reset = 1'b1;
        idle_inputs();
        repeat (reset_cycles) @(posedge clk);
        #1;
        reset = 1'b0;
        clear_model();
    endtask

    // Access and responder stimulus, driven just after the rising edge
    task automatic drive_cycle(int access_pct, int creg_pct, int ready_pct, int mode);
        int k;
        access_en = rand_below(100) < access_pct;
        access_thread = thread_idx_t'(rand_below(threads_per_core));
        access_store = rand_below(2) == 1;
        access_value = $random(seed);
        access_addr = $random(seed);                   // Random reserved bits too
        if (rand_below(100) < creg_pct) begin
            access_addr.creg.region = creg_region;
            access_addr.creg.index = pick_index(mode);
        end else if (access_addr.io.region == creg_region) begin
            access_addr.io.region = 16'h0;             // Keep it on the I/O side
        end
        ii_ready = rand_below(100) < ready_pct;
        ii_response_valid = 1'b0;
        if (accepted.size() > 0 && rand_below(4) == 0) begin   // Random delay
            k = rand_below(accepted.size());
            ii_response_valid = 1'b1;
            ii_response_thread = accepted[k];
            ii_response_value = $random(seed);
            accepted.delete(k);
        end
    endtask

    // Checks at the falling edge, then model update for the coming edge
    task automatic sample_cycle();
        thread_idx_t t;
        control_register_t index;
        @(negedge clk);
        check_pulse("creg_result_valid", creg_result_valid, exp_creg);
        if (exp_creg && creg_result_valid) begin
            check_creg_result(exp_creg_thread, exp_creg_value);
        end
        check_pulse("access_rollback", access_rollback, exp_rollback);
        if (exp_rollback && access_rollback) begin
            check_rollback(exp_rollback_thread);
            rollbacks_seen++;
        end
        check_pulse("io_done_valid", io_done_valid, exp_done);
        if (exp_done && io_done_valid) begin
            check_io_done(exp_done_thread, exp_done_value);
        end
        check_pulse("ior_request_valid", ior_request_valid, any_pending(1'b1));
        t = ior_request_thread;
        if (ior_request_valid && (!busy[t] || sent[t])) begin
            report_failure($sformatf("Thread %0d appeared on the I/O bus with no request", t));
        end else if (ior_request_valid) begin
            check_io_request(t, req_store[t], req_addr[t], req_value[t]);
            if (ii_ready) begin
                sent[t] = 1'b1;                        // Transfers at the coming edge
                accepted.push_back(t);
            end
        end
        exp_creg = 1'b0;
        exp_rollback = 1'b0;
        exp_done = 1'b0;
        t = access_thread;
        index = control_register_t'(access_addr[5:2]);
        if (access_en && access_addr[31:16] == creg_region) begin
            exp_creg = 1'b1;
            exp_creg_thread = t;
            case (index)
                cr_thread_id: exp_creg_value = scalar_t'(t);
                cr_trap_handler: exp_creg_value = trap;
                cr_cycle_count: exp_creg_value = cycles;
                cr_scratchpad0: exp_creg_value = sp0[t];
                cr_scratchpad1: exp_creg_value = sp1[t];
                default: exp_creg_value = '0;
            endcase
            if (access_store) begin
                case (index)
                    cr_trap_handler: trap = access_value;
                    cr_scratchpad0: sp0[t] = access_value;
                    cr_scratchpad1: sp1[t] = access_value;
                    default: ;
                endcase
            end
        end else if (access_en && busy[t]) begin
            exp_rollback = 1'b1;                       // Dropped, never on the bus
            exp_rollback_thread = t;
        end else if (access_en) begin
            busy[t] = 1'b1;
            sent[t] = 1'b0;
            req_store[t] = access_store;
            req_addr[t] = access_addr;
            req_value[t] = access_value;
        end
        if (ii_response_valid) begin
            t = ii_response_thread;
            exp_done = 1'b1;
            exp_done_thread = t;
            exp_done_value = req_store[t] ? '0 : ii_response_value;
            busy[t] = 1'b0;
            sent[t] = 1'b0;
        end
        cycles++;
    endtask

    task automatic run_cycle(int access_pct, int creg_pct, int ready_pct, int mode);
        drive_cycle(access_pct, creg_pct, ready_pct, mode);
        sample_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic start_test();
        test_errors = 0;
        rollbacks_seen = 0;
    endtask

    task automatic end_test(string name);
        int n;
        n = 0;
        while (any_pending(1'b0) && n < drain_limit) begin
            run_cycle(0, 0, 100, 0);
            n++;
        end
        if (any_pending(1'b0)) begin
            report_failure("I/O requests still outstanding after the drain limit");
        end
        run_cycle(0, 0, 100, 0);                       // Last completion pulse
        tests_run++;
        if (test_errors > 0) begin
            tests_failed++;
        end
        $display("Test %s %s with %0d errors", name, test_errors == 0 ? "passed" : "failed",
            test_errors);
    endtask

    initial begin
        apply_reset();
        start_test();
        repeat (200) run_cycle(60, 100, 50, 0);
        end_test("creg_file");
        start_test();
        repeat (150) run_cycle(60, 100, 50, 1);
        end_test("creg_ids");
        start_test();
        repeat (300) run_cycle(40, 0, 70, 0);
        end_test("io_issue");
        start_test();
        repeat (120) run_cycle(60, 0, 0, 0);           // Bus stalled, threads stay pending
        if (rollbacks_seen == 0) begin
            report_failure("No rollback seen while all threads were pending");
        end
        end_test("io_rollback");
        start_test();
        repeat (400) run_cycle(70, 30, 40, 0);
        end_test("io_mixed");
        start_test();
        repeat (60) run_cycle(70, 30, 40, 0);
        apply_reset();                                 // Traffic in flight
        repeat (40) run_cycle(0, 0, 50, 0);            // Outputs must stay quiet
        repeat (70) run_cycle(70, 30, 40, 0);
        end_test("reset_mid");
        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: sim.f
source/core_defs_pkg.sv
source/io_bus_pkg.sv
source/io_access_if.sv
source/access_dispatch.sv
source/control_registers.sv
source/io_request_queue.sv
source/io_access_unit.sv
testbench/io_access_unit_sva.sv
testbench/io_access_unit_tb.sv

// File: Makefile
# Verilator flow for the I/O access unit testbench
TOP := io_access_unit_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f sim.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -Mdir obj_dir -o sim_bin
	./obj_dir/sim_bin | awk '{ print } /^STATUS: PASS$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir
